/* common/cell_switch_macros.svh */
/*
 * Switch sizing. CELL_PORT_BITS must equal log2(CELL_PORTS).
 */
`ifndef CELL_SWITCH_MACROS_SVH
`define CELL_SWITCH_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIFO sizing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address width, so depth is 2**AW cells.
`define CELL_FIFO_AW 3

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output ports.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CELL_PORTS 4
// Low dst bits that pick the port.
`define CELL_PORT_BITS 2

`endif

/* common/cell_pkg.sv */
/*
 * Cell types shared by the switch. A cell is one 48-bit word.
 */
`include "cell_switch_macros.svh"

package cell_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Cell word.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Packed as {src, dst, data}, src in the top byte.
   typedef struct packed {
      // Source address.
      logic [7:0]  src;
      // Destination address, low bits route the cell.
      logic [7:0]  dst;
      // Payload.
      logic [31:0] data;
   } cell_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Port index.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Wide enough for every output port.
   typedef logic [`CELL_PORT_BITS-1:0] port_t;

endpackage

/* cell_fifo/cell_fifo.sv */
/*
 * Synchronous cell FIFO, depth 2**AW. Writes while full and reads while
 * empty are ignored. rd_cell is registered, valid the cycle after rd_en.
 */
`timescale 1ns/1ps
`include "cell_switch_macros.svh"

module cell_fifo #(
   parameter int AW = `CELL_FIFO_AW
) (
   input  logic            clk,
   input  logic            rstp,
   input  logic            wr_en,
   input  cell_pkg::cell_t wr_cell,
   input  logic            rd_en,
   output cell_pkg::cell_t rd_cell,
   output logic            empty,
   output logic            full
);

   // Number of cell slots.
   localparam int DEPTH = 1 << AW;
   // Depth at count width, for the full compare.
   localparam logic [AW:0] DEPTH_CNT = DEPTH[AW:0];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Storage and pointers.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Circular buffer of cells.
   cell_pkg::cell_t mem [DEPTH];

   // Next slot to write.
   logic [AW-1:0] head;
   // Oldest stored cell.
   logic [AW-1:0] tail;
   // Occupancy, one bit wider so a full buffer is distinct.
   logic [AW:0]   count;

   // Qualified strobes.
   logic do_wr;
   logic do_rd;

   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   // Store the incoming cell.
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[head] <= wr_cell;
      end
   end

   // Head advances on each accepted write.
   always_ff @(posedge clk or posedge rstp) begin
      if (rstp) begin
         head <= '0;
      end else if (do_wr) begin
         head <= head + 1'b1;
      end
   end

   // Tail advances on each accepted read.
   always_ff @(posedge clk or posedge rstp) begin
      if (rstp) begin
         tail <= '0;
      end else if (do_rd) begin
         tail <= tail + 1'b1;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Occupancy and flags.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Read and write in the same cycle leave the count alone.
   always_ff @(posedge clk or posedge rstp) begin
      if (rstp) begin
         count <= '0;
      end else begin
         case ({do_rd, do_wr})
            2'b01:   count <= count + 1'b1;
            2'b10:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Flags straight from the count.
   assign empty = (count == '0);
   assign full  = (count == DEPTH_CNT);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Output register.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Samples the slot under the tail.
   // Loaded only while a cell is held, so unwritten slots never show.
   always_ff @(posedge clk or posedge rstp) begin
      if (rstp) begin
         rd_cell <= '0;
      end else if (!empty) begin
         rd_cell <= mem[tail];
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Checks.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Receiver must respect back-pressure.
   a_no_write_full: assert property (
      @(posedge clk) disable iff (rstp) wr_en |-> !full
   ) else $error("cell_fifo: write while full");

   // Dispatcher must not pop an empty FIFO.
   a_no_read_empty: assert property (
      @(posedge clk) disable iff (rstp) rd_en |-> !empty
   ) else $error("cell_fifo: read while empty");

   // Count never wraps into a state that is both.
   a_flags_exclusive: assert property (
      @(posedge clk) disable iff (rstp) !(full && empty)
   ) else $error("cell_fifo: full and empty together");

endmodule

/* rtl/cell_rx.sv */
/*
 * Four-phase input receiver. A cell is taken only while the FIFO has
 * room, so a full FIFO holds in_ack low and stalls the sender.
 */
`timescale 1ns/1ps

module cell_rx (
   input  logic            clk,
   input  logic            rstp,
   input  logic            in_req,
   input  cell_pkg::cell_t in_cell,
   output logic            in_ack,
   output logic            wr_en,
   output cell_pkg::cell_t wr_cell,
   input  logic            full
);

   // Handshake phase.
   typedef enum logic {
      RX_IDLE,
      RX_ACKED
   } rx_state_t;

   rx_state_t state;
   rx_state_t state_nxt;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Handshake FSM.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk or posedge rstp) begin
      if (rstp) begin
         state <= RX_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         // Accept once a slot is free.
         RX_IDLE: begin
            if (in_req && !full) begin
               state_nxt = RX_ACKED;
            end
         end
         // Hold ack until the sender lets go.
         RX_ACKED: begin
            if (!in_req) begin
               state_nxt = RX_IDLE;
            end
         end
         default: state_nxt = RX_IDLE;
      endcase
   end

   // Single write pulse at acceptance.
   assign wr_en   = (state == RX_IDLE) && in_req && !full;
   // Sender holds the cell stable while req is up.
   assign wr_cell = in_cell;
   // Ack follows the accepting edge.
   assign in_ack  = (state == RX_ACKED);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Checks.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Never push into a full FIFO.
   a_wr_not_full: assert property (
      @(posedge clk) disable iff (rstp) wr_en |-> !full
   ) else $error("cell_rx: write while full");

endmodule

/* rtl/cell_tx.sv */
/*
 * Dispatcher. Pops one cell at a time and runs a four-phase transfer on
 * the port picked by the low dst bits. A slow ack stalls the whole path.
 */
`timescale 1ns/1ps
`include "cell_switch_macros.svh"

module cell_tx (
   input  logic                   clk,
   input  logic                   rstp,
   input  logic                   empty,
   output logic                   rd_en,
   input  cell_pkg::cell_t        rd_cell,
   output logic [`CELL_PORTS-1:0] out_req,
   input  logic [`CELL_PORTS-1:0] out_ack,
   output cell_pkg::cell_t        out_cell
);

   // Transfer phase.
   typedef enum logic [1:0] {
      TX_IDLE,
      TX_FETCH,
      TX_REQ,
      TX_RELEASE
   } tx_state_t;

   tx_state_t       state;
   tx_state_t       state_nxt;
   // Port of the cell in flight.
   cell_pkg::port_t port_q;
   // Ack of that port.
   logic            ack_sel;

   assign ack_sel = out_ack[port_q];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Transfer FSM.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk or posedge rstp) begin
      if (rstp) begin
         state <= TX_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         // Pop as soon as a cell waits.
         TX_IDLE: begin
            if (!empty) begin
               state_nxt = TX_FETCH;
            end
         end
         // Registered FIFO output is valid here.
         TX_FETCH: state_nxt = TX_REQ;
         // Req up until the port acks.
         TX_REQ: begin
            if (ack_sel) begin
               state_nxt = TX_RELEASE;
            end
         end
         // Wait for ack low before the next cell.
         TX_RELEASE: begin
            if (!ack_sel) begin
               state_nxt = TX_IDLE;
            end
         end
         default: state_nxt = TX_IDLE;
      endcase
   end

   // One-cycle pop.
   assign rd_en = (state == TX_IDLE) && !empty;

   // Latch the popped cell.
   always_ff @(posedge clk) begin
      if (state == TX_FETCH) begin
         out_cell <= rd_cell;
      end
   end

   // Port select from the low dst bits.
   always_ff @(posedge clk or posedge rstp) begin
      if (rstp) begin
         port_q <= '0;
      end else if (state == TX_FETCH) begin
         port_q <= rd_cell.dst[`CELL_PORT_BITS-1:0];
      end
   end

   // Drive only the selected req.
   always_comb begin
      out_req = '0;
      if (state == TX_REQ) begin
         out_req[port_q] = 1'b1;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Checks.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // At most one port requested.
   a_req_onehot: assert property (
      @(posedge clk) disable iff (rstp) $onehot0(out_req)
   ) else $error("cell_tx: more than one out_req");

   // Cell held for the whole request.
   a_cell_stable: assert property (
      @(posedge clk) disable iff (rstp) (|out_req) |=> $stable(out_cell)
   ) else $error("cell_tx: out_cell changed during req");

endmodule

/* rtl/cell_switch.sv */
/*
 * Cell switch top. One four-phase input, CELL_PORTS four-phase outputs,
 * cells routed in arrival order by the low dst bits. Single clock.
 */
`timescale 1ns/1ps
`include "cell_switch_macros.svh"

module cell_switch (
   input  logic                   clk,
   input  logic                   rstp,
   input  logic                   in_req,
   input  cell_pkg::cell_t        in_cell,
   output logic                   in_ack,
   output logic [`CELL_PORTS-1:0] out_req,
   input  logic [`CELL_PORTS-1:0] out_ack,
   output cell_pkg::cell_t        out_cell
);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Internal links.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Receiver to FIFO.
   logic            wr_en;
   cell_pkg::cell_t wr_cell;
   logic            full;
   // FIFO to dispatcher.
   logic            rd_en;
   cell_pkg::cell_t rd_cell;
   logic            empty;

   // Input side.
   cell_rx u_cell_rx (
      .clk     (clk),
      .rstp    (rstp),
      .in_req  (in_req),
      .in_cell (in_cell),
      .in_ack  (in_ack),
      .wr_en   (wr_en),
      .wr_cell (wr_cell),
      .full    (full)
   );

   // Cell queue.
   cell_fifo #(
      .AW (`CELL_FIFO_AW)
   ) u_cell_fifo (
      .clk     (clk),
      .rstp    (rstp),
      .wr_en   (wr_en),
      .wr_cell (wr_cell),
      .rd_en   (rd_en),
      .rd_cell (rd_cell),
      .empty   (empty),
      .full    (full)
   );

   // Output side.
   cell_tx u_cell_tx (
      .clk      (clk),
      .rstp     (rstp),
      .empty    (empty),
      .rd_en    (rd_en),
      .rd_cell  (rd_cell),
      .out_req  (out_req),
      .out_ack  (out_ack),
      .out_cell (out_cell)
   );

endmodule

/* test/tb_cell_switch.sv */
/*
 * Testbench for the cell switch. Sends random cells over the input link
 * and answers each output port with a random ack delay of 0 to 7 cycles.
 */
`timescale 1ns/1ps
`include "cell_switch_macros.svh"

module tb_cell_switch;

   localparam int NUM_CELLS      = 200;
   localparam int CLK_PERIOD     = 100;
   localparam int TIMEOUT_CYCLES = NUM_CELLS * 40;

   logic                   clk;
   logic                   rstp;
   logic                   in_req;
   cell_pkg::cell_t        in_cell;
   logic                   in_ack;
   logic [`CELL_PORTS-1:0] out_req;
   logic [`CELL_PORTS-1:0] out_ack;
   cell_pkg::cell_t        out_cell;

   // Cells accepted by the DUT, oldest first.
   cell_pkg::cell_t        exp_q[$];
   int                     seed = 32'h0069ceb3;
   int                     errors;
   int                     sent;
   int                     received;
   // Cells that waited more than one cycle for in_ack.
   int                     stalled;
   // Acks as seen by the DUT at the last rising edge.
   logic [`CELL_PORTS-1:0] ack_at_edge;
   logic [`CELL_PORTS-1:0] req_prev;

   cell_switch u_cell_switch (
      .clk      (clk),
      .rstp     (rstp),
      .in_req   (in_req),
      .in_cell  (in_cell),
      .in_ack   (in_ack),
      .out_req  (out_req),
      .out_ack  (out_ack),
      .out_cell (out_cell)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reference model and stimulus.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Port is dst modulo the port count.
   function automatic cell_pkg::port_t expected_port(input cell_pkg::cell_t c);
      return cell_pkg::port_t'(c.dst % `CELL_PORTS);
   endfunction

   // One full four-phase transfer on the input link.
   task automatic send_cell(input cell_pkg::cell_t c);
      int waits;
      waits   = 0;
      in_cell = c;
      in_req  = 1'b1;
      do begin
         @(negedge clk);
         waits++;
      end while (!in_ack);
      if (waits > 1) stalled++;
      exp_q.push_back(c);
      sent++;
      in_req = 1'b0;
      do @(negedge clk); while (in_ack);
   endtask

   // Answers one output port, forever.
   task automatic respond_port(input int p);
      int delay;
      forever begin
         @(negedge clk);
         if (out_req[p] && !out_ack[p]) begin
            delay = $random(seed) & 7;
            repeat (delay) @(negedge clk);
            out_ack[p] = 1'b1;
            do @(negedge clk); while (out_req[p]);
            out_ack[p] = 1'b0;
         end
      end
   endtask

   // Inputs are stable here, set on the falling edge.
   always @(posedge clk) ack_at_edge <= out_ack;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Scoreboard, sampled mid-cycle.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      cell_pkg::cell_t exp;
      req_prev = '0;
      forever begin
         @(negedge clk);
         if (!rstp) begin
            if ($countones(out_req) > 1)
               $display("Mismatch at %0t: out_req %b has more than one bit set",
                        $time, out_req);
            if ($countones(out_req) > 1) errors++;
            for (int p = 0; p < `CELL_PORTS; p++) begin
               // New transfer on port p.
               if (out_req[p] && !req_prev[p]) begin
                  received++;
                  if (exp_q.size() == 0) begin
                     $display("Error at %0t: port %0d sent a cell that was never accepted",
                              $time, p);
                     errors++;
                  end else begin
                     exp = exp_q.pop_front();
                     if (expected_port(exp) != p) begin
                        $display("Mismatch at %0t: cell dst %h on port %0d, expected %0d",
                                 $time, exp.dst, p, expected_port(exp));
                        errors++;
                     end
                     if (out_cell !== exp) begin
                        $display("Mismatch at %0t: got %h/%h/%h, expected %h/%h/%h",
                                 $time, out_cell.src, out_cell.dst, out_cell.data,
                                 exp.src, exp.dst, exp.data);
                        errors++;
                     end
                  end
               end
               // Req may only drop once the port has acked.
               if (!out_req[p] && req_prev[p] && !ack_at_edge[p]) begin
                  $display("Mismatch at %0t: out_req[%0d] fell before its ack rose",
                           $time, p);
                  errors++;
               end
            end
            req_prev = out_req;
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Main sequence.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      cell_pkg::cell_t cells [NUM_CELLS];
      int r;
      rstp     = 1'b1;
      in_req   = 1'b0;
      in_cell  = '0;
      out_ack  = '0;
      errors   = 0;
      sent     = 0;
      received = 0;
      stalled  = 0;
      repeat (8) @(negedge clk);
      rstp = 1'b0;
      @(negedge clk);
      // Outputs quiet after reset.
      if (in_ack !== 1'b0 || out_req !== '0) begin
         $display("Mismatch at %0t: after reset in_ack=%b out_req=%b, expected 0",
                  $time, in_ack, out_req);
         errors++;
      end
      // Whole cell stream drawn before the responders start.
      for (int i = 0; i < NUM_CELLS; i++) begin
         r             = $random(seed);
         cells[i].src  = r[7:0];
         r             = $random(seed);
         cells[i].dst  = r[7:0];
         cells[i].data = $random(seed);
      end
      fork
         respond_port(0);
         respond_port(1);
         respond_port(2);
         respond_port(3);
      join_none
      for (int i = 0; i < NUM_CELLS; i++) begin
         send_cell(cells[i]);
      end
      wait (received >= NUM_CELLS);
      // Time for any duplicate to show up.
      repeat (40) @(negedge clk);
      if (received != sent) begin
         $display("Error: %0d cells sent but %0d received", sent, received);
         errors++;
      end
      if (stalled == 0) begin
         $display("Error: the input link never saw back-pressure");
         errors++;
      end
      $display("Done: %0d errors, %0d of %0d cells received, %0d stalled",
               errors, received, sent, stalled);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Watchdog, 40 cycles per cell.
   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Timeout: only %0d of %0d cells arrived, %0d errors",
               received, NUM_CELLS, errors);
      $display("TEST FAILED");
      $finish;
   end

endmodule

/* compile.f */
+incdir+common
common/cell_pkg.sv
cell_fifo/cell_fifo.sv
rtl/cell_rx.sv
rtl/cell_tx.sv
rtl/cell_switch.sv
test/tb_cell_switch.sv

/* Bender.yml */
package:
  name: cell_switch

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cell_pkg.sv
      - cell_fifo/cell_fifo.sv
      - rtl/cell_rx.sv
      - rtl/cell_tx.sv
      - rtl/cell_switch.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/tb_cell_switch.sv
